// File: verilog.f
synth_pkg.sv
slot_sequencer.sv
note_latch.sv
osc_bank.sv
env_bank.sv
voice_mixer.sv
synth_engine.sv
synth_checker.sv
tb_synth_engine.sv

// File: tb_synth_engine.sv
`timescale 1ns/100ps

module tb_synth_engine
    import synth_pkg::*;
;

    localparam int CYCLE_LIMIT = 2000;  // 6 tests x 30 frames x 8 cycles, plus margin

    logic              AUDIO_CLK;
    logic              rst_n;
    logic              trig;
    logic              note_on;
    logic              note_off;
    voice_t            note_voice;
    key_t              note_key;
    vel_t              note_vel;
    sound_t            sound_out;
    logic              sample_valid;
    logic              run;
    logic              frame_done;
    logic [VOICES-1:0] voice_free;

    int          errors = 0;
    int          cycles = 0;
    logic [31:0] rng;
    string       test_name;

    // reference model, one entry per voice
    int m_phase  [VOICES];
    int m_level  [VOICES];
    int m_key    [VOICES];
    int m_vel    [VOICES];
    bit m_gate   [VOICES];
    bit m_retrig [VOICES];
    int semi_tab [12] = '{64, 68, 72, 76, 81, 85, 91, 96, 102, 108, 114, 121};

    synth_engine u_dut (
        .AUDIO_CLK    ( AUDIO_CLK ),
        .rst_n        ( rst_n ),
        .trig         ( trig ),
        .note_on      ( note_on ),
        .note_off     ( note_off ),
        .note_voice   ( note_voice ),
        .note_key     ( note_key ),
        .note_vel     ( note_vel ),
        .sound_out    ( sound_out ),
        .sample_valid ( sample_valid ),
        .run          ( run ),
        .frame_done   ( frame_done ),
        .voice_free   ( voice_free )
    );

    initial begin
        AUDIO_CLK = 1'b0;
        forever #5 AUDIO_CLK = ~AUDIO_CLK;
    end

    always @(posedge AUDIO_CLK) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        errors++;
        $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
    endtask

    // one frame of the reference: phase step, envelope step, weighted sum
    task automatic model_frame(output sound_t exp_sound);
        int incr;
        int sample;
        int sum;
        sum = 0;
        for (int v = 0; v < VOICES; v++) begin
            incr = (semi_tab[m_key[v] % 12] << (m_key[v] / 12)) & 'hffff;
            if (m_retrig[v]) begin
                m_phase[v] = 0;
            end else begin
                m_phase[v] = (m_phase[v] + incr) & 'hffff;
            end
            m_retrig[v] = 1'b0;
            if (m_gate[v]) begin
                m_level[v] = (m_level[v] + ATTACK_STEP > LEVEL_MAX) ?
                             LEVEL_MAX : m_level[v] + ATTACK_STEP;
            end else begin
                m_level[v] = (m_level[v] < RELEASE_STEP) ? 0 : m_level[v] - RELEASE_STEP;
            end
            sample = m_phase[v] >> 8;
            if (sample > 127) begin
                sample = sample - 256;      // top byte read as signed
            end
            sum = sum + sample * m_level[v] * m_vel[v];
        end
        exp_sound = sound_t'(sum >>> MIX_SHIFT);
    endtask

    task automatic run_frame(input bit extra_trig);
        sound_t            exp_sound;
        logic [VOICES-1:0] exp_free;
        model_frame(exp_sound);
        for (int v = 0; v < VOICES; v++) begin
            exp_free[v] = !m_gate[v] && (m_level[v] == 0);
        end
        trig = 1'b1;
        @(negedge AUDIO_CLK);
        trig = 1'b0;
        if (extra_trig) begin
            repeat (2) @(negedge AUDIO_CLK);
            trig = 1'b1;                    // lands while run is high
            @(negedge AUDIO_CLK);
            trig = 1'b0;
        end
        do @(negedge AUDIO_CLK); while (!sample_valid);
        assert (sound_out === exp_sound) else report_mismatch("sound_out", exp_sound, sound_out);
        assert (voice_free === exp_free) else report_mismatch("voice_free", exp_free, voice_free);
        if (extra_trig) begin
            repeat (8) begin
                @(negedge AUDIO_CLK);
                assert (!sample_valid) else begin
                    errors++;
                    $display("%s: a trig during run produced an extra sample", test_name);
                end
            end
        end
    endtask

    task automatic start_note(input int v);
        rng        = next_random(rng);
        note_on    = 1'b1;
        note_voice = voice_t'(v);
        note_key   = rng[6:0];
        note_vel   = rng[14:8];
        m_key[v]    = rng[6:0];
        m_vel[v]    = rng[14:8];
        m_gate[v]   = 1'b1;
        m_retrig[v] = 1'b1;
        @(negedge AUDIO_CLK);
        note_on = 1'b0;
    endtask

    task automatic stop_note(input int v);
        note_off   = 1'b1;
        note_voice = voice_t'(v);
        m_gate[v]  = 1'b0;
        @(negedge AUDIO_CLK);
        note_off = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        trig       = 1'b0;
        note_on    = 1'b0;
        note_off   = 1'b0;
        note_voice = '0;
        note_key   = '0;
        note_vel   = '0;
        rng        = 32'h2203c76e;
        for (int v = 0; v < VOICES; v++) begin
            m_phase[v]  = 0;
            m_level[v]  = 0;
            m_key[v]    = 0;
            m_vel[v]    = 0;
            m_gate[v]   = 1'b0;
            m_retrig[v] = 1'b0;
        end
        repeat (10) @(negedge AUDIO_CLK);
        rst_n = 1'b1;
        @(negedge AUDIO_CLK);

        test_name = "reset";
        assert (!run && !frame_done && !sample_valid) else begin
            errors++;
            $display("reset: run, frame_done or sample_valid is high after reset");
        end
        assert (voice_free === '1) else report_mismatch("voice_free", 4'hf, voice_free);
        repeat (2) run_frame(1'b0);

        test_name = "frame_timing";
        run_frame(1'b1);

        test_name = "single_note_attack";
        start_note(1);
        repeat (10) run_frame(1'b0);

        test_name = "release";
        stop_note(1);
        repeat (20) run_frame(1'b0);       // 255 down to 0 takes 16 frames

        test_name = "four_voices";
        for (int v = 0; v < VOICES; v++) begin
            start_note(v);
        end
        repeat (20) run_frame(1'b0);

        test_name = "retrigger";
        start_note(2);                      // voice 2 is sounding at full level
        repeat (4) run_frame(1'b0);

        $display("errors: %0d compare, %0d assertion", errors, u_dut.u_synth_checker.fail_count);
        if (errors == 0 && u_dut.u_synth_checker.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: synth_checker.sv
`timescale 1ns/100ps

module synth_checker
    import synth_pkg::*;
(
    input logic              AUDIO_CLK,
    input logic              rst_n,
    input logic              trig,
    input logic              run,
    input logic              frame_done,
    input logic              sample_valid,
    input sound_t            sound_out,
    input logic [VOICES-1:0] voice_free
);

    // sample_valid is set at the sixth edge after trig, seen one edge later
    localparam int TRIG_TO_SAMPLE = VOICES + 3;

    int   fail_count = 0;
    logic taken_q;
    logic accepted;

    // the trig right after an accepted one still sees run low but is dropped
    assign accepted = trig && !run && !taken_q;

    always_ff @(posedge AUDIO_CLK or negedge rst_n) begin
        if (!rst_n) begin
            taken_q <= 1'b0;
        end else begin
            taken_q <= accepted;
        end
    end

    trig_to_sample: assert property (@(posedge AUDIO_CLK) disable iff (!rst_n)
        accepted |-> ##TRIG_TO_SAMPLE sample_valid)
        else begin fail_count++; $error("no sample_valid after an accepted trig"); end

    sample_from_trig: assert property (@(posedge AUDIO_CLK) disable iff (!rst_n)
        sample_valid |-> $past(accepted, TRIG_TO_SAMPLE))
        else begin fail_count++; $error("sample_valid without a matching trig"); end

    run_held: assert property (@(posedge AUDIO_CLK) disable iff (!rst_n)
        accepted |-> ##2 (run && !frame_done) [*VOICES-1] ##1 (run && frame_done))
        else begin fail_count++; $error("run dropped before frame_done"); end

    frame_done_pulse: assert property (@(posedge AUDIO_CLK) disable iff (!rst_n)
        frame_done |=> !frame_done)
        else begin fail_count++; $error("frame_done longer than one cycle"); end

    sample_pulse: assert property (@(posedge AUDIO_CLK) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else begin fail_count++; $error("sample_valid longer than one cycle"); end

    outputs_known: assert property (@(posedge AUDIO_CLK) disable iff (!rst_n)
        !$isunknown({sound_out, sample_valid, run, frame_done, voice_free}))
        else begin fail_count++; $error("output is X after reset"); end

endmodule

bind synth_engine synth_checker u_synth_checker (
    .AUDIO_CLK    ( AUDIO_CLK ),
    .rst_n        ( rst_n ),
    .trig         ( trig ),
    .run          ( run ),
    .frame_done   ( frame_done ),
    .sample_valid ( sample_valid ),
    .sound_out    ( sound_out ),
    .voice_free   ( voice_free )
);

// File: synth_engine.sv
`timescale 1ns/100ps

module synth_engine
    import synth_pkg::*;
(
    input  logic               AUDIO_CLK,
    input  logic               rst_n,
    input  logic               trig,
    input  logic               note_on,
    input  logic               note_off,
    input  voice_t             note_voice,
    input  key_t               note_key,
    input  vel_t               note_vel,
    output sound_t             sound_out,
    output logic               sample_valid,
    output logic               run,
    output logic               frame_done,
    output logic [VOICES-1:0]  voice_free
);

    slot_t                    slot;
    voice_note_t [VOICES-1:0] notes;
    logic        [VOICES-1:0] retrig;
    osc_out_t                 osc_out;
    env_out_t                 env_out;

    slot_sequencer u_slot_sequencer (
        .AUDIO_CLK    ( AUDIO_CLK ),
        .rst_n        ( rst_n ),
        .trig         ( trig ),
        .slot         ( slot ),
        .run          ( run ),
        .frame_done   ( frame_done )
    );

    note_latch u_note_latch (
        .AUDIO_CLK    ( AUDIO_CLK ),
        .rst_n        ( rst_n ),
        .note_on      ( note_on ),
        .note_off     ( note_off ),
        .note_voice   ( note_voice ),
        .note_key     ( note_key ),
        .note_vel     ( note_vel ),
        .slot         ( slot ),     // clears retrigger flags
        .notes        ( notes ),
        .retrig       ( retrig )
    );

    osc_bank u_osc_bank (
        .AUDIO_CLK    ( AUDIO_CLK ),
        .rst_n        ( rst_n ),
        .slot         ( slot ),
        .notes        ( notes ),
        .retrig       ( retrig ),
        .osc_out      ( osc_out )
    );

    env_bank u_env_bank (
        .AUDIO_CLK    ( AUDIO_CLK ),
        .rst_n        ( rst_n ),
        .slot         ( slot ),
        .notes        ( notes ),
        .env_out      ( env_out ),
        .voice_free   ( voice_free )
    );

    voice_mixer u_voice_mixer (
        .AUDIO_CLK    ( AUDIO_CLK ),
        .rst_n        ( rst_n ),
        .osc_out      ( osc_out ),
        .env_out      ( env_out ),
        .notes        ( notes ),    // velocity lookup
        .sound_out    ( sound_out ),
        .sample_valid ( sample_valid )
    );

endmodule

// File: voice_mixer.sv
`timescale 1ns/100ps

module voice_mixer
    import synth_pkg::*;
(
    input  logic                      AUDIO_CLK,
    input  logic                      rst_n,
    input  osc_out_t                  osc_out,
    input  env_out_t                  env_out,
    input  voice_note_t [VOICES-1:0]  notes,
    output sound_t                    sound_out,
    output logic                      sample_valid
);

    logic signed [ACC_W-1:0] acc;       // frame sum so far
    logic signed [ACC_W-1:0] prod;
    logic signed [ACC_W-1:0] sum;
    logic signed [ACC_W-1:0] shifted;
    logic                    tag_ok;
    logic                    last_voice;
    vel_t                    vel;

    always_comb begin
        tag_ok     = osc_out.valid && env_out.valid && (osc_out.voice == env_out.voice);
        last_voice = (osc_out.voice == voice_t'(VOICES - 1));
        vel        = notes[osc_out.voice].vel;
        // level and velocity are magnitudes, zero-extended before the signed multiply
        prod       = osc_out.sample * $signed({1'b0, env_out.level}) * $signed({1'b0, vel});
        sum        = acc + prod;
        shifted    = sum >>> MIX_SHIFT;
    end

    always_ff @(posedge AUDIO_CLK or negedge rst_n) begin
        if (!rst_n) begin
            acc          <= '0;
            sound_out    <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= 1'b0;
            if (tag_ok) begin
                if (last_voice) begin
                    sound_out    <= shifted[SOUND_W-1:0];   // truncate
                    sample_valid <= 1'b1;
                    acc          <= '0;                     // ready for next frame
                end else begin
                    acc <= sum;
                end
            end
        end
    end

endmodule

// File: env_bank.sv
`timescale 1ns/100ps

module env_bank
    import synth_pkg::*;
(
    input  logic                      AUDIO_CLK,
    input  logic                      rst_n,
    input  slot_t                     slot,
    input  voice_note_t [VOICES-1:0]  notes,
    output env_out_t                  env_out,
    output logic        [VOICES-1:0]  voice_free
);

    level_t           level_mem [VOICES];   // one level per voice
    level_t           cur_level;
    logic [LEVEL_W:0] attack_sum;           // carry bit for saturation
    level_t           next_level;

    always_comb begin
        cur_level  = level_mem[slot.voice];
        attack_sum = {1'b0, cur_level} + (LEVEL_W + 1)'(ATTACK_STEP);
        if (notes[slot.voice].gate) begin
            if (attack_sum > (LEVEL_W + 1)'(LEVEL_MAX)) begin
                next_level = level_t'(LEVEL_MAX);
            end else begin
                next_level = attack_sum[LEVEL_W-1:0];
            end
        end else begin
            if (cur_level >= level_t'(RELEASE_STEP)) begin
                next_level = cur_level - level_t'(RELEASE_STEP);
            end else begin
                next_level = '0;            // floor
            end
        end
    end

    // free once released and fully decayed
    always_comb begin
        for (int v = 0; v < VOICES; v++) begin
            voice_free[v] = !notes[v].gate && (level_mem[v] == '0);
        end
    end

    always_ff @(posedge AUDIO_CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < VOICES; v++) begin
                level_mem[v] <= '0;
            end
            env_out <= '0;
        end else begin
            env_out.valid <= slot.valid;
            if (slot.valid) begin
                level_mem[slot.voice] <= next_level;
                env_out.voice         <= slot.voice;
                env_out.level         <= next_level;
            end
        end
    end

endmodule

// File: osc_bank.sv
`timescale 1ns/100ps

module osc_bank
    import synth_pkg::*;
(
    input  logic                      AUDIO_CLK,
    input  logic                      rst_n,
    input  slot_t                     slot,
    input  voice_note_t [VOICES-1:0]  notes,
    input  logic        [VOICES-1:0]  retrig,
    output osc_out_t                  osc_out
);

    phase_t      phase_mem [VOICES];    // one accumulator per voice
    voice_note_t cur_note;
    logic [3:0]  semi;
    logic [3:0]  octave;
    phase_t      incr;
    phase_t      next_phase;

    // key to increment: table lookup on the semitone, then one
    // doubling per octave, wrapping at 16 bits
    always_comb begin
        cur_note   = notes[slot.voice];
        semi       = 4'(cur_note.key % 12);
        octave     = 4'(cur_note.key / 12);
        incr       = SEMI_INCR[semi] << octave;
        if (retrig[slot.voice]) begin
            next_phase = '0;            // note_on restarts the wave
        end else begin
            next_phase = phase_mem[slot.voice] + incr;
        end
    end

    always_ff @(posedge AUDIO_CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int v = 0; v < VOICES; v++) begin
                phase_mem[v] <= '0;
            end
            osc_out <= '0;
        end else begin
            osc_out.valid <= slot.valid;
            if (slot.valid) begin
                phase_mem[slot.voice] <= next_phase;
                osc_out.voice         <= slot.voice;
                osc_out.sample        <= sample_t'(next_phase[PHASE_W-1 -: SAMPLE_W]); // saw
            end
        end
    end

endmodule

// File: note_latch.sv
`timescale 1ns/100ps

module note_latch
    import synth_pkg::*;
(
    input  logic                      AUDIO_CLK,
    input  logic                      rst_n,
    input  logic                      note_on,
    input  logic                      note_off,
    input  voice_t                    note_voice,
    input  key_t                      note_key,
    input  vel_t                      note_vel,
    input  slot_t                     slot,
    output voice_note_t [VOICES-1:0]  notes,
    output logic        [VOICES-1:0]  retrig
);

    // Per-voice note store. A note_on also arms a retrigger flag, which
    // stays up until the voice's slot has gone by, so the oscillator sees
    // it exactly once.
    always_ff @(posedge AUDIO_CLK or negedge rst_n) begin
        if (!rst_n) begin
            notes  <= '0;
            retrig <= '0;
        end else begin
            for (int v = 0; v < VOICES; v++) begin
                if (slot.valid && slot.voice == voice_t'(v)) begin
                    retrig[v] <= 1'b0;      // consumed by osc_bank
                end
            end
            if (note_on) begin              // wins over note_off
                notes[note_voice].key  <= note_key;
                notes[note_voice].vel  <= note_vel;
                notes[note_voice].gate <= 1'b1;
                retrig[note_voice]     <= 1'b1;
            end else if (note_off) begin
                notes[note_voice].gate <= 1'b0;
            end
        end
    end

endmodule

// File: slot_sequencer.sv
`timescale 1ns/100ps

module slot_sequencer
    import synth_pkg::*;
(
    input  logic  AUDIO_CLK,
    input  logic  rst_n,
    input  logic  trig,
    output slot_t slot,
    output logic  run,
    output logic  frame_done
);

    seq_state_t state;
    voice_t     cnt;        // next voice to issue

    always_ff @(posedge AUDIO_CLK or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            cnt        <= '0;
            slot       <= '0;
            run        <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            slot.valid <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                IDLE: begin
                    run <= 1'b0;
                    if (trig && !run) begin     // run still high in the cycle after the last slot
                        state <= SCAN;
                        cnt   <= '0;
                    end
                end
                SCAN: begin
                    slot.valid <= 1'b1;
                    slot.voice <= cnt;
                    run        <= 1'b1;
                    cnt        <= cnt + 1'b1;
                    if (cnt == voice_t'(VOICES - 1)) begin
                        frame_done <= 1'b1;     // with the last slot
                        state      <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// File: synth_pkg.sv
package synth_pkg;

    localparam int VOICES       = 4;
    localparam int V_WIDTH      = 2;
    localparam int PHASE_W      = 16;
    localparam int SAMPLE_W     = 8;
    localparam int LEVEL_W      = 8;
    localparam int KEY_W        = 7;
    localparam int SOUND_W      = 16;
    localparam int ACC_W        = 26;    // four full-scale products plus sign
    localparam int LEVEL_MAX    = 255;
    localparam int ATTACK_STEP  = 32;    // per frame, gate on
    localparam int RELEASE_STEP = 16;    // per frame, gate off
    localparam int MIX_SHIFT    = 9;

    typedef logic        [V_WIDTH-1:0]  voice_t;
    typedef logic        [KEY_W-1:0]    key_t;
    typedef logic        [KEY_W-1:0]    vel_t;
    typedef logic        [PHASE_W-1:0]  phase_t;
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic        [LEVEL_W-1:0]  level_t;
    typedef logic signed [SOUND_W-1:0]  sound_t;

    // octave 0 phase increments, C up to B
    localparam phase_t SEMI_INCR [12] = '{
        16'd64, 16'd68, 16'd72, 16'd76, 16'd81, 16'd85,
        16'd91, 16'd96, 16'd102, 16'd108, 16'd114, 16'd121
    };

    typedef struct packed {
        logic   valid;
        voice_t voice;
    } slot_t;

    typedef struct packed {
        key_t key;
        vel_t vel;
        logic gate;
    } voice_note_t;

    typedef struct packed {
        logic    valid;
        voice_t  voice;
        sample_t sample;
    } osc_out_t;

    typedef struct packed {
        logic   valid;
        voice_t voice;
        level_t level;
    } env_out_t;

    typedef enum logic {
        IDLE,
        SCAN
    } seq_state_t;

endpackage
